// File: design/bus_pkg.sv
`include "io_defines.svh"

package bus_pkg;

  // one word on the io bus
  typedef logic [`IO_ADDR_W-1:0] io_addr_t;
  typedef logic [`IO_DATA_W-1:0] io_data_t;

  // top nibble of the address picks the peripheral
  typedef logic [`IO_SLOT_W-1:0] io_slot_t;

  // one classic cycle at a time
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    RESP
  } bus_state_t;

endpackage

// File: design/io_bus_fsm.sv
`timescale 1ns/100ps
`include "io_defines.svh"

module io_bus_fsm (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    cyc_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  bus_pkg::io_addr_t       addr_i,
  input  bus_pkg::io_data_t       wdata_i,
  input  logic                    seg_ack_i,
  input  bus_pkg::io_data_t       seg_rdata_i,
  input  logic                    timer_ack_i,
  input  bus_pkg::io_data_t       timer_rdata_i,
  output logic                    ack_o,
  output logic                    err_o,
  output bus_pkg::io_data_t       rdata_o,
  output logic                    per_we_o,
  output logic [`IO_OFFSET_W-1:0] per_offset_o,
  output bus_pkg::io_data_t       per_wdata_o,
  output logic                    seg_stb_o,
  output logic                    timer_stb_o,
  output logic                    bus_err_o
);
  import bus_pkg::*;

  bus_state_t state_q;
  bus_state_t state_d;
  io_addr_t   addr_q;
  io_data_t   wdata_q;
  io_data_t   rdata_q;
  logic       we_q;
  io_slot_t   slot;
  logic       hit_seg;
  logic       hit_timer;
  logic       per_ack;

  ////////////////////////////////////////
  // slot decode on the latched address
  assign slot      = addr_q[`IO_ADDR_W-1 -: `IO_SLOT_W];
  assign hit_seg   = (slot == `IO_SLOT_SEG);
  assign hit_timer = (slot == `IO_SLOT_TIMER);
  assign per_ack   = (hit_seg && seg_ack_i) || (hit_timer && timer_ack_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cyc_i && stb_i) begin
          state_d = ISSUE;
        end
      end
      // unmapped slots end here with err
      ISSUE: state_d = (hit_seg || hit_timer) ? WAIT : IDLE;
      WAIT: begin
        if (per_ack) begin
          state_d = RESP;
        end
      end
      RESP:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request and response data
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cyc_i && stb_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
    if (state_q == WAIT && per_ack) begin
      rdata_q <= hit_seg ? seg_rdata_i : timer_rdata_i;
    end
  end

  ////////////////////////////////////////
  // strobes and master response
  assign seg_stb_o    = (state_q == ISSUE) && hit_seg;
  assign timer_stb_o  = (state_q == ISSUE) && hit_timer;
  assign err_o        = (state_q == ISSUE) && !(hit_seg || hit_timer);
  assign bus_err_o    = err_o;
  assign ack_o        = (state_q == RESP);
  assign rdata_o      = rdata_q;
  assign per_we_o     = we_q;
  assign per_offset_o = addr_q[`IO_OFFSET_W+1:2];
  assign per_wdata_o  = wdata_q;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ack_o && err_o))
    else $error("ack_o and err_o high together");

  a_one_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    !(seg_stb_o && timer_stb_o))
    else $error("more than one peripheral strobe");

endmodule

// File: design/io_subsys.sv
`timescale 1ns/100ps
`include "io_defines.svh"

module io_subsys (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  bus_pkg::io_addr_t addr_i,
  input  bus_pkg::io_data_t wdata_i,
  output logic              ack_o,
  output logic              err_o,
  output bus_pkg::io_data_t rdata_o,
  input  logic              int_en_i,
  input  logic              int_ack_i,
  output irq_pkg::exc_num_t exception_o,
  output logic [6:0]        hex0_o,
  output logic [6:0]        hex1_o,
  output logic [6:0]        hex2_o,
  output logic [6:0]        hex3_o,
  output logic [6:0]        hex4_o,
  output logic [6:0]        hex5_o,
  output logic [6:0]        hex6_o,
  output logic [6:0]        hex7_o
);
  import bus_pkg::*;
  import irq_pkg::*;

  // shared peripheral side of the io bus
  logic                    per_we;
  logic [`IO_OFFSET_W-1:0] per_offset;
  io_data_t                per_wdata;
  logic                    seg_stb;
  logic                    seg_ack;
  io_data_t                seg_rdata;
  logic                    timer_stb;
  logic                    timer_ack;
  io_data_t                timer_rdata;
  logic                    bus_err_pulse;
  irq_vec_t                timer_irq;

  io_bus_fsm bus0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cyc_i         (cyc_i),
    .stb_i         (stb_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .seg_ack_i     (seg_ack),
    .seg_rdata_i   (seg_rdata),
    .timer_ack_i   (timer_ack),
    .timer_rdata_i (timer_rdata),
    .ack_o         (ack_o),
    .err_o         (err_o),
    .rdata_o       (rdata_o),
    .per_we_o      (per_we),
    .per_offset_o  (per_offset),
    .per_wdata_o   (per_wdata),
    .seg_stb_o     (seg_stb),
    .timer_stb_o   (timer_stb),
    .bus_err_o     (bus_err_pulse)
  );

  timer_unit timer0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .stb_i    (timer_stb),
    .we_i     (per_we),
    .offset_i (per_offset),
    .wdata_i  (per_wdata),
    .ack_o    (timer_ack),
    .rdata_o  (timer_rdata),
    .irq_o    (timer_irq)
  );

  seg_display seg0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .stb_i    (seg_stb),
    .we_i     (per_we),
    .offset_i (per_offset),
    .wdata_i  (per_wdata),
    .ack_o    (seg_ack),
    .rdata_o  (seg_rdata),
    .hex0_o   (hex0_o),
    .hex1_o   (hex1_o),
    .hex2_o   (hex2_o),
    .hex3_o   (hex3_o),
    .hex4_o   (hex4_o),
    .hex5_o   (hex5_o),
    .hex6_o   (hex6_o),
    .hex7_o   (hex7_o)
  );

  irq_encoder intenc0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_err_i   (bus_err_pulse),
    .timer_irq_i (timer_irq),
    .int_en_i    (int_en_i),
    .int_ack_i   (int_ack_i),
    .exception_o (exception_o)
  );

endmodule

// File: design/irq_encoder.sv
`timescale 1ns/100ps
`include "io_defines.svh"

module irq_encoder (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              bus_err_i,
  input  irq_pkg::irq_vec_t timer_irq_i,
  input  logic              int_en_i,
  input  logic              int_ack_i,
  output irq_pkg::exc_num_t exception_o
);
  import irq_pkg::*;

  logic     err_q;
  logic     err_pending;
  exc_num_t exc_d;
  exc_num_t exc_q;

  ////////////////////////////////////////
  // sticky bus error until the cpu acks
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else if (bus_err_i) begin
      err_q <= 1'b1;
    end else if (int_ack_i) begin
      err_q <= 1'b0;
    end
  end

  // the pulse itself counts so the error shows one edge after err_o
  assign err_pending = bus_err_i || err_q;

  // bus error first, then lowest timer channel
  always_comb begin
    exc_d = EXC_NONE;
    if (int_en_i) begin
      if (err_pending) begin
        exc_d = EXC_BUS_ERR;
      end else begin
        for (int k = `TIMER_CHANNELS - 1; k >= 0; k--) begin
          if (timer_irq_i[k]) begin
            exc_d = exc_num_t'(EXC_TIMER0 + k);
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exc_q <= EXC_NONE;
    end else begin
      exc_q <= exc_d;
    end
  end

  assign exception_o = exc_q;

  a_masked: assert property (@(posedge clk_i) disable iff (rst_i)
    !int_en_i |=> exception_o == EXC_NONE)
    else $error("exception raised while interrupts disabled");

endmodule

// File: design/irq_pkg.sv
`include "io_defines.svh"

package irq_pkg;

  // one level per timer compare channel
  typedef logic [`TIMER_CHANNELS-1:0] irq_vec_t;

  // exception number handed to the cpu
  typedef logic [`IRQ_EXC_W-1:0] exc_num_t;

  localparam exc_num_t EXC_NONE    = 4'd0;
  localparam exc_num_t EXC_BUS_ERR = 4'd1;
  // channel k maps to EXC_TIMER0 + k
  localparam exc_num_t EXC_TIMER0  = 4'd2;

endpackage

// File: design/seg_display.sv
`timescale 1ns/100ps
`include "io_defines.svh"

module seg_display (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  logic [`IO_OFFSET_W-1:0] offset_i,
  input  bus_pkg::io_data_t       wdata_i,
  output logic                    ack_o,
  output bus_pkg::io_data_t       rdata_o,
  output logic [6:0]              hex0_o,
  output logic [6:0]              hex1_o,
  output logic [6:0]              hex2_o,
  output logic [6:0]              hex3_o,
  output logic [6:0]              hex4_o,
  output logic [6:0]              hex5_o,
  output logic [6:0]              hex6_o,
  output logic [6:0]              hex7_o
);
  import bus_pkg::*;

  io_data_t               digits_q;
  logic [`SEG_DIGITS-1:0] blank_q;
  io_data_t               rdata_q;
  logic                   ack_q;
  logic [6:0]             hex [`SEG_DIGITS];

  // segment a in bit 0, active low
  function automatic logic [6:0] hex_font(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  ////////////////////////////////////////
  // register writes
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      digits_q <= '0;
      blank_q  <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= stb_i;
      if (stb_i && we_i && offset_i == `SEG_REG_DIGITS) begin
        digits_q <= wdata_i;
      end
      if (stb_i && we_i && offset_i == `SEG_REG_BLANK) begin
        blank_q <= wdata_i[`SEG_DIGITS-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      case (offset_i)
        `SEG_REG_DIGITS: rdata_q <= digits_q;
        `SEG_REG_BLANK:  rdata_q <= io_data_t'(blank_q);
        default:         rdata_q <= '0;
      endcase
    end
  end

  // blanked digit drives all segments off
  always_comb begin
    for (int k = 0; k < `SEG_DIGITS; k++) begin
      hex[k] = blank_q[k] ? 7'h7f : hex_font(digits_q[4*k +: 4]);
    end
  end

  assign hex0_o  = hex[0];
  assign hex1_o  = hex[1];
  assign hex2_o  = hex[2];
  assign hex3_o  = hex[3];
  assign hex4_o  = hex[4];
  assign hex5_o  = hex[5];
  assign hex6_o  = hex[6];
  assign hex7_o  = hex[7];
  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i |=> ack_o)
    else $error("display ack missing after strobe");

endmodule

// File: design/timer_unit.sv
`timescale 1ns/100ps
`include "io_defines.svh"

module timer_unit (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    stb_i,
  input  logic                    we_i,
  input  logic [`IO_OFFSET_W-1:0] offset_i,
  input  bus_pkg::io_data_t       wdata_i,
  output logic                    ack_o,
  output bus_pkg::io_data_t       rdata_o,
  output irq_pkg::irq_vec_t       irq_o
);
  import bus_pkg::*;
  import irq_pkg::*;

  localparam int CH_W = $clog2(`TIMER_CHANNELS);

  io_data_t        count_q;
  io_data_t        cmp_q [`TIMER_CHANNELS];
  irq_vec_t        ctrl_q;
  irq_vec_t        status_q;
  irq_vec_t        match;
  irq_vec_t        w1c;
  logic            wr;
  logic            cmp_sel;
  logic [CH_W-1:0] cmp_idx;
  io_data_t        rdata_d;
  io_data_t        rdata_q;
  logic            ack_q;

  assign wr      = stb_i && we_i;
  assign cmp_sel = (offset_i >= `TIMER_REG_CMP0) &&
                   (offset_i < `TIMER_REG_CMP0 + `TIMER_CHANNELS);
  assign cmp_idx = CH_W'(offset_i - `TIMER_REG_CMP0);
  assign w1c     = (wr && offset_i == `TIMER_REG_STATUS) ?
                   wdata_i[`TIMER_CHANNELS-1:0] : '0;

  // a channel fires only while enabled
  always_comb begin
    for (int k = 0; k < `TIMER_CHANNELS; k++) begin
      match[k] = ctrl_q[k] && (count_q == cmp_q[k]);
    end
  end

  ////////////////////////////////////////
  // free-running counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (wr && offset_i == `TIMER_REG_COUNT) begin
      count_q <= wdata_i;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q   <= '0;
      status_q <= '0;
      for (int k = 0; k < `TIMER_CHANNELS; k++) begin
        cmp_q[k] <= '0;
      end
    end else begin
      if (wr && offset_i == `TIMER_REG_CTRL) begin
        ctrl_q <= wdata_i[`TIMER_CHANNELS-1:0];
      end
      if (wr && cmp_sel) begin
        cmp_q[cmp_idx] <= wdata_i;
      end
      // a match in the same cycle beats the clear
      status_q <= (status_q & ~w1c) | match;
    end
  end

  ////////////////////////////////////////
  // register readback
  always_comb begin
    rdata_d = '0;
    if (cmp_sel) begin
      rdata_d = cmp_q[cmp_idx];
    end else begin
      case (offset_i)
        `TIMER_REG_COUNT:  rdata_d = count_q;
        `TIMER_REG_CTRL:   rdata_d = io_data_t'(ctrl_q);
        `TIMER_REG_STATUS: rdata_d = io_data_t'(status_q);
        default:           rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (stb_i) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  assign irq_o   = status_q;

  // single strobe per access, answered in the next cycle
  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i |=> ack_o && !stb_i)
    else $error("timer ack not exactly one cycle after a single strobe");

endmodule

// File: files.f
+incdir+include
design/bus_pkg.sv
design/irq_pkg.sv
design/io_bus_fsm.sv
design/timer_unit.sv
design/seg_display.sv
design/irq_encoder.sv
design/io_subsys.sv
tests/tb_io_subsys.sv

// File: include/io_defines.svh
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// io bus geometry
`define IO_ADDR_W       12
`define IO_DATA_W       32
`define IO_SLOT_W       4
`define IO_OFFSET_W     4

// slots without a peripheral raise a bus error
`define IO_SLOT_SEG     4'd0
`define IO_SLOT_TIMER   4'd8

// timer register word offsets
`define TIMER_CHANNELS  4
`define TIMER_REG_COUNT  0
`define TIMER_REG_CTRL   1
`define TIMER_REG_STATUS 2
`define TIMER_REG_CMP0   4

// display registers
`define SEG_DIGITS      8
`define SEG_REG_DIGITS  0
`define SEG_REG_BLANK   1

// exception number width seen by the cpu
`define IRQ_EXC_W       4

`endif

// File: tests/tb_io_subsys.sv
`timescale 1ns/100ps
`include "io_defines.svh"

module tb_io_subsys;
  import bus_pkg::*;

  localparam logic [3:0] EXC_NUM_ERR    = 4'd1;
  localparam logic [3:0] EXC_NUM_TIMER0 = 4'd2;
  localparam int         BUS_TIMEOUT    = 16;
  localparam int         IRQ_TIMEOUT    = 128;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  io_addr_t    addr_i;
  io_data_t    wdata_i;
  logic        ack_o;
  logic        err_o;
  io_data_t    rdata_o;
  logic        int_en_i;
  logic        int_ack_i;
  logic [3:0]  exception_o;
  logic [6:0]  hex_out [8];

  // expected values, kept up to date by the stimulus tasks
  logic        rst_q = 1'b0;
  logic        exp_err;
  logic        rd_chk;
  io_data_t    exp_rdata;
  logic        hex_chk_en;
  io_data_t    exp_digits;
  logic [7:0]  exp_blank;
  logic [6:0]  exp_hex [8];
  logic        exc_chk_en;
  logic [3:0]  exp_exc;
  logic [31:0] lcg_state;

  io_subsys DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o),
    .int_en_i    (int_en_i),
    .int_ack_i   (int_ack_i),
    .exception_o (exception_o),
    .hex0_o      (hex_out[0]),
    .hex1_o      (hex_out[1]),
    .hex2_o      (hex_out[2]),
    .hex3_o      (hex_out[3]),
    .hex4_o      (hex_out[4]),
    .hex5_o      (hex_out[5]),
    .hex6_o      (hex_out[6]),
    .hex7_o      (hex_out[7])
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    rst_q <= rst_i;
  end

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic io_addr_t make_addr(input int slot, input int offset);
    return {4'(slot), 2'b00, 4'(offset), 2'b00};
  endfunction

  // lit segments per digit, a is bit 0, outputs are active low
  function automatic logic [6:0] font_of(input logic [3:0] nib);
    string      lit;
    logic [6:0] pat;
    int         idx;
    case (nib)
      4'h0: lit = "abcdef";
      4'h1: lit = "bc";
      4'h2: lit = "abdeg";
      4'h3: lit = "abcdg";
      4'h4: lit = "bcfg";
      4'h5: lit = "acdfg";
      4'h6: lit = "acdefg";
      4'h7: lit = "abc";
      4'h8: lit = "abcdefg";
      4'h9: lit = "abcdfg";
      4'ha: lit = "abcefg";
      4'hb: lit = "cdefg";
      4'hc: lit = "adef";
      4'hd: lit = "bcdeg";
      4'he: lit = "adefg";
      default: lit = "aefg";
    endcase
    pat = 7'h7f;
    for (int i = 0; i < lit.len(); i++) begin
      idx = int'(lit[i]) - int'("a");
      pat[3'(idx)] = 1'b0;
    end
    return pat;
  endfunction

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      exp_hex[k] = exp_blank[k] ? 7'h7f : font_of(exp_digits[4*k +: 4]);
    end
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    fail_stop($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp_val, act_val));
  endtask

  ////////////////////////////////////////
  // bus master
  task automatic bus_cycle(input logic we, input io_addr_t addr, input io_data_t data);
    int       waited;
    io_slot_t slot;
    @(negedge clk_i);
    slot    = addr[`IO_ADDR_W-1 -: 4];
    exp_err = !(slot == `IO_SLOT_SEG || slot == `IO_SLOT_TIMER);
    cyc_i   = 1'b1;
    stb_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = data;
    waited  = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!(ack_o || err_o) && waited < BUS_TIMEOUT);
    if (!(ack_o || err_o)) begin
      fail_stop("no response to bus cycle");
    end
    // hold through the response edge
    @(posedge clk_i);
    @(negedge clk_i);
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic bus_write(input io_addr_t addr, input io_data_t data);
    rd_chk = 1'b0;
    bus_cycle(1'b1, addr, data);
  endtask

  task automatic bus_read(input io_addr_t addr, input io_data_t expect_val, input logic check);
    rd_chk    = check;
    exp_rdata = expect_val;
    bus_cycle(1'b0, addr, '0);
    rd_chk    = 1'b0;
  endtask

  task automatic display_write(input int offset, input io_data_t data);
    hex_chk_en = 1'b0;
    bus_write(make_addr(`IO_SLOT_SEG, offset), data);
    if (offset == `SEG_REG_BLANK) begin
      exp_blank = data[7:0];
    end else begin
      exp_digits = data;
    end
    hex_chk_en = 1'b1;
    bus_read(make_addr(`IO_SLOT_SEG, offset), data, 1'b1);
  endtask

  // wait until exception_o does (or does not) equal val
  task automatic wait_exception(input logic [3:0] val, input logic equal, input string what);
    int n;
    n = 0;
    while (((exception_o == val) != equal) && n < IRQ_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if ((exception_o == val) != equal) begin
      fail_stop(what);
    end
  endtask

  task automatic pulse_int_ack();
    @(negedge clk_i);
    int_ack_i = 1'b1;
    @(negedge clk_i);
    int_ack_i = 1'b0;
  endtask

  // count from 0 up to a compare value well past the setup writes
  task automatic arm_timer(input int k);
    io_data_t cmp_val;
    cmp_val = 32'd40 + io_data_t'(next_rand() >> 28);
    bus_write(make_addr(`IO_SLOT_TIMER, `TIMER_REG_CTRL), '0);
    bus_write(make_addr(`IO_SLOT_TIMER, `TIMER_REG_COUNT), '0);
    bus_write(make_addr(`IO_SLOT_TIMER, `TIMER_REG_CMP0 + k), cmp_val);
    bus_write(make_addr(`IO_SLOT_TIMER, `TIMER_REG_CTRL), io_data_t'(1) << k);
    exc_chk_en = 1'b0;
    wait_exception(4'd0, 1'b0, "timer interrupt never reached exception_o");
    exp_exc    = 4'(EXC_NUM_TIMER0 + k);
    exc_chk_en = 1'b1;
  endtask

  task automatic clear_timer(input int k);
    exc_chk_en = 1'b0;
    bus_write(make_addr(`IO_SLOT_TIMER, `TIMER_REG_STATUS), io_data_t'(1) << k);
    wait_exception(4'd0, 1'b1, "exception_o not cleared after the status write");
    exp_exc    = 4'd0;
    exc_chk_en = 1'b1;
  endtask

  ////////////////////////////////////////
  // checks
  a_rst_ack: assert property (@(posedge clk_i) rst_q |-> !ack_o)
    else value_error("ack_o", 32'd0, 32'($sampled(ack_o)));

  a_rst_err: assert property (@(posedge clk_i) rst_q |-> !err_o)
    else value_error("err_o", 32'd0, 32'($sampled(err_o)));

  for (genvar k = 0; k < 8; k++) begin : g_hex
    a_hex: assert property (@(posedge clk_i) (rst_q || hex_chk_en) |-> hex_out[k] == exp_hex[k])
      else value_error($sformatf("hex%0d_o", k), 32'($sampled(exp_hex[k])),
                       32'($sampled(hex_out[k])));
  end

  a_exc: assert property (@(posedge clk_i) (rst_q || exc_chk_en) |-> exception_o == exp_exc)
    else value_error("exception_o", 32'($sampled(exp_exc)), 32'($sampled(exception_o)));

  // mapped slot answers at the third edge after the request edge
  a_ack_mapped: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(stb_i) && cyc_i && !exp_err |-> ##1 !ack_o ##1 !ack_o ##1 ack_o)
    else value_error("ack_o", 32'(!$sampled(ack_o)), 32'($sampled(ack_o)));

  a_err_edge: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(stb_i) && cyc_i |-> ##1 err_o == exp_err)
    else value_error("err_o", 32'($sampled(exp_err)), 32'($sampled(err_o)));

  a_no_ack_unmapped: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(stb_i) && cyc_i && exp_err |-> ##1 !ack_o ##1 !ack_o ##1 !ack_o)
    else value_error("ack_o", 32'd0, 32'($sampled(ack_o)));

  a_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o && rd_chk |-> rdata_o == exp_rdata)
    else value_error("rdata_o", $sampled(exp_rdata), $sampled(rdata_o));

  a_err_exc: assert property (@(posedge clk_i) disable iff (rst_i)
    err_o && int_en_i |=> exception_o == EXC_NUM_ERR)
    else value_error("exception_o", 32'(EXC_NUM_ERR), 32'($sampled(exception_o)));

  a_gated: assert property (@(posedge clk_i) disable iff (rst_i)
    !int_en_i |=> exception_o == 4'd0)
    else value_error("exception_o", 32'd0, 32'($sampled(exception_o)));

  ////////////////////////////////////////
  // stimulus
  initial begin
    logic [31:0] r;
    int          offset;
    int          k;
    cyc_i      = 1'b0;
    stb_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    int_en_i   = 1'b0;
    int_ack_i  = 1'b0;
    rst_i      = 1'b1;
    exp_err    = 1'b0;
    rd_chk     = 1'b0;
    exp_rdata  = '0;
    hex_chk_en = 1'b0;
    exp_digits = '0;
    exp_blank  = '0;
    exc_chk_en = 1'b0;
    exp_exc    = 4'd0;
    lcg_state  = 32'h08311723;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i      = 1'b0;
    hex_chk_en = 1'b1;
    exc_chk_en = 1'b1;

    // random mapped accesses, display writes with readback and zero timer registers
    for (int n = 0; n < 20; n++) begin
      r = next_rand();
      if (r[31]) begin
        offset = r[30] ? `SEG_REG_BLANK : `SEG_REG_DIGITS;
        display_write(offset, r[30] ? (next_rand() & 32'hff) : next_rand());
      end else begin
        offset = r[29] ? (`TIMER_REG_CMP0 + int'(r[28:27])) :
                 (r[26] ? `TIMER_REG_CTRL : `TIMER_REG_STATUS);
        bus_read(make_addr(`IO_SLOT_TIMER, offset), '0, 1'b1);
      end
    end

    // unmapped slots with interrupts still masked
    for (int n = 0; n < 4; n++) begin
      r = next_rand();
      if (r[31:28] == `IO_SLOT_SEG || r[31:28] == `IO_SLOT_TIMER) begin
        r[28] = 1'b1;
      end
      bus_read(make_addr(int'(r[31:28]), int'(r[27:24])), '0, 1'b0);
    end
    pulse_int_ack();
    @(negedge clk_i);
    int_en_i = 1'b1;

    for (int ch = 0; ch < `TIMER_CHANNELS; ch++) begin
      arm_timer(ch);
      bus_read(make_addr(`IO_SLOT_TIMER, `TIMER_REG_STATUS), io_data_t'(1) << ch, 1'b1);
      clear_timer(ch);
      bus_read(make_addr(`IO_SLOT_TIMER, `TIMER_REG_STATUS), '0, 1'b1);
    end

    // bus error outranks a pending timer channel
    k = int'(next_rand() >> 30);
    arm_timer(k);
    exc_chk_en = 1'b0;
    bus_read(make_addr(4'd5, 0), '0, 1'b0);
    exp_exc    = EXC_NUM_ERR;
    exc_chk_en = 1'b1;
    repeat (2) @(negedge clk_i);
    exc_chk_en = 1'b0;
    pulse_int_ack();
    wait_exception(EXC_NUM_ERR, 1'b0, "bus error not released by int_ack_i");
    exp_exc    = 4'(EXC_NUM_TIMER0 + k);
    exc_chk_en = 1'b1;
    repeat (2) @(negedge clk_i);

    // masked with both sources pending
    int_en_i   = 1'b0;
    exc_chk_en = 1'b0;
    bus_read(make_addr(4'd13, 0), '0, 1'b0);
    pulse_int_ack();
    exp_exc    = 4'd0;
    exc_chk_en = 1'b1;
    clear_timer(k);
    @(negedge clk_i);
    int_en_i = 1'b1;
    repeat (4) @(negedge clk_i);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
